/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_i2c_periph
FILELIST = i2c_periph_top.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* i2c_byte_fifo.sv */
// 16-entry byte fifo between the two buses, decodes its own wdata, rdata and flush offsets
module i2c_byte_fifo (
  input  logic                       rst_i,         // clock
  input  logic                       clk_i,         // async reset, active high
  input  logic                       wr_bus_apb_i,  // 1: apb writes, i2c reads
  input  i2c_periph_pkg::apb_bus_t   apb_i,
  input  i2c_periph_pkg::i2c_bus_t   i2c_i,
  output i2c_periph_pkg::fifo_stat_t stat_o,
  output i2c_periph_pkg::data_t      head_o
);

  i2c_periph_pkg::reg_idx_t wdata_ofs, rdata_ofs, flush_ofs;
  logic apb_wr, apb_rd;
  logic wr_hit, rd_hit;
  i2c_periph_pkg::data_t wr_byte;

  logic push_q, pop_q, flush_q;
  i2c_periph_pkg::data_t push_data_q;
  i2c_periph_pkg::data_t mem [i2c_periph_pkg::FIFO_DEPTH];
  i2c_periph_pkg::ptr_t wptr_q, rptr_q;
  i2c_periph_pkg::level_t count_q;
  i2c_periph_pkg::fifo_stat_t stat_q;
  logic empty, full, do_push, do_pop;

  // offset base follows the direction tie
  assign wdata_ofs = wr_bus_apb_i ? i2c_periph_pkg::OFS_FIFO_TO_I2C_WDATA
                                  : i2c_periph_pkg::OFS_FIFO_TO_APB_WDATA;
  assign rdata_ofs = wr_bus_apb_i ? i2c_periph_pkg::OFS_FIFO_TO_I2C_RDATA
                                  : i2c_periph_pkg::OFS_FIFO_TO_APB_RDATA;
  assign flush_ofs = wr_bus_apb_i ? i2c_periph_pkg::OFS_FIFO_TO_I2C_FLUSH
                                  : i2c_periph_pkg::OFS_FIFO_TO_APB_FLUSH;

  assign apb_wr = apb_i.we && i2c_periph_pkg::apb_in_map(apb_i.waddr);
  assign apb_rd = apb_i.rd_done && i2c_periph_pkg::apb_in_map(apb_i.raddr);

  always_comb begin
    if (wr_bus_apb_i) begin
      wr_hit  = apb_wr && (i2c_periph_pkg::apb_index(apb_i.waddr) == wdata_ofs);
      wr_byte = apb_i.wdata[7:0];
      rd_hit  = i2c_i.rd_done && (i2c_i.addr == rdata_ofs);
    end else begin
      wr_hit  = i2c_i.we && (i2c_i.addr == wdata_ofs);
      wr_byte = i2c_i.wdata;
      rd_hit  = apb_rd && (i2c_periph_pkg::apb_index(apb_i.raddr) == rdata_ofs);
    end
  end

  assign empty   = (count_q == '0);
  assign full    = (count_q == i2c_periph_pkg::level_t'(i2c_periph_pkg::FIFO_DEPTH));
  assign do_push = push_q && !full;  // full drops the byte
  assign do_pop  = pop_q && !empty;

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      push_q  <= 1'b0;
      pop_q   <= 1'b0;
      flush_q <= 1'b0;
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
      stat_q  <= '{level: '0, full: 1'b0, empty: 1'b1};
    end else begin
      push_q <= wr_hit;
      pop_q  <= rd_hit;
      // either side may flush, apb wins a same-cycle clash
      if (apb_wr && i2c_periph_pkg::apb_index(apb_i.waddr) == flush_ofs) begin
        flush_q <= apb_i.wdata[0];
      end else if (i2c_i.we && i2c_i.addr == flush_ofs) begin
        flush_q <= i2c_i.wdata[0];
      end
      if (flush_q) begin  // held empty while flush is set
        wptr_q  <= '0;
        rptr_q  <= '0;
        count_q <= '0;
      end else begin
        if (do_push) wptr_q <= wptr_q + 1'b1;
        if (do_pop) rptr_q <= rptr_q + 1'b1;
        case ({do_push, do_pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
      stat_q <= '{level: count_q, full: full, empty: empty};  // one cycle behind count
    end
  end

  always_ff @(posedge rst_i) begin
    push_data_q <= wr_byte;
    if (do_push && !flush_q) mem[wptr_q] <= push_data_q;
  end

  assign stat_o = stat_q;
  assign head_o = empty ? '0 : mem[rptr_q];  // empty reads as zero

endmodule

/* i2c_periph_assertions.sv */
// concurrent checks on interrupts and fifo status, bound into the bridge top level
module i2c_periph_assertions (
  input logic                       rst_i,  // clock
  input logic                       clk_i,  // async reset, active high
  input logic [2:0]                 i2c_irq_en_i,
  input logic [2:0]                 apb_irq_en_i,
  input logic                       i2c_irq_i,
  input logic                       apb_irq_i,
  input i2c_periph_pkg::fifo_stat_t to_apb_stat_i,
  input i2c_periph_pkg::fifo_stat_t to_i2c_stat_i
);

  // no enable, no interrupt
  i2c_irq_quiet: assert property (@(posedge rst_i) disable iff (clk_i)
    (i2c_irq_en_i == 3'b000) |-> !i2c_irq_i)
    else $error("i2c interrupt high with every i2c enable bit clear");

  apb_irq_quiet: assert property (@(posedge rst_i) disable iff (clk_i)
    (apb_irq_en_i == 3'b000) |-> !apb_irq_i)
    else $error("apb interrupt high with every apb enable bit clear");

  // 16 entries at most
  level_in_range: assert property (@(posedge rst_i) disable iff (clk_i)
    (to_apb_stat_i.level <= 5'd16) && (to_i2c_stat_i.level <= 5'd16))
    else $error("fifo level above 16");

  to_apb_flags_exclusive: assert property (@(posedge rst_i) disable iff (clk_i)
    !(to_apb_stat_i.empty && to_apb_stat_i.full))
    else $error("fifo toward apb shows empty and full together");

  to_i2c_flags_exclusive: assert property (@(posedge rst_i) disable iff (clk_i)
    !(to_i2c_stat_i.empty && to_i2c_stat_i.full))
    else $error("fifo toward i2c shows empty and full together");

endmodule

/* i2c_periph_csr.sv */
// configuration and interrupt registers plus the registered apb and i2c read ports
module i2c_periph_csr (
  input  logic                       rst_i,  // clock
  input  logic                       clk_i,  // async reset, active high
  input  i2c_periph_pkg::apb_bus_t   apb_i,
  input  i2c_periph_pkg::i2c_bus_t   i2c_i,
  input  i2c_periph_pkg::mbox_stat_t mbox_i,
  input  i2c_periph_pkg::fifo_stat_t to_apb_stat_i,
  input  i2c_periph_pkg::fifo_stat_t to_i2c_stat_i,
  input  i2c_periph_pkg::data_t      to_apb_head_i,
  input  i2c_periph_pkg::data_t      to_i2c_head_i,
  output logic [31:0]                apb_rdata_o,
  output i2c_periph_pkg::data_t      i2c_rdata_o,
  output i2c_periph_pkg::i2c_cfg_t   cfg_o,
  output logic                       i2c_irq_o,
  output logic                       apb_irq_o
);

  i2c_periph_pkg::i2c_cfg_t cfg_q;
  logic [2:0] i2c_irq_en_q, apb_irq_en_q;
  logic [2:0] i2c_irq_stat, apb_irq_stat;
  logic apb_wr;
  i2c_periph_pkg::reg_idx_t apb_widx, apb_ridx;
  i2c_periph_pkg::data_t apb_rd_mux, i2c_rd_mux;
  logic [31:0] apb_rdata_q;
  i2c_periph_pkg::data_t i2c_rdata_q;

  assign apb_wr   = apb_i.we && i2c_periph_pkg::apb_in_map(apb_i.waddr);
  assign apb_widx = i2c_periph_pkg::apb_index(apb_i.waddr);
  assign apb_ridx = i2c_periph_pkg::apb_index(apb_i.raddr);

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      cfg_q <= '{
        dev_addr:  i2c_periph_pkg::DEF_DEV_ADDR,
        enable:    1'b0,
        debounce:  i2c_periph_pkg::DEF_DEBOUNCE,
        scl_delay: i2c_periph_pkg::DEF_SCL_DELAY,
        sda_delay: i2c_periph_pkg::DEF_SDA_DELAY
      };
      i2c_irq_en_q <= '0;
      apb_irq_en_q <= '0;
    end else begin
      if (apb_wr) begin  // config is apb-only
        case (i2c_periph_pkg::reg_ofs_e'(apb_widx))
          i2c_periph_pkg::OFS_DEV_ADDR:       cfg_q.dev_addr  <= apb_i.wdata[6:0];
          i2c_periph_pkg::OFS_ENABLE:         cfg_q.enable    <= apb_i.wdata[0];
          i2c_periph_pkg::OFS_DEBOUNCE:       cfg_q.debounce  <= apb_i.wdata[7:0];
          i2c_periph_pkg::OFS_SCL_DELAY:      cfg_q.scl_delay <= apb_i.wdata[7:0];
          i2c_periph_pkg::OFS_SDA_DELAY:      cfg_q.sda_delay <= apb_i.wdata[7:0];
          i2c_periph_pkg::OFS_APB_IRQ_ENABLE: apb_irq_en_q    <= apb_i.wdata[2:0];
          default: ;
        endcase
      end
      if (i2c_i.we && i2c_i.addr == i2c_periph_pkg::OFS_I2C_IRQ_ENABLE) begin
        i2c_irq_en_q <= i2c_i.wdata[2:0];
      end
    end
  end

  // each side: own mailbox, data waiting for me, room toward the other side
  assign i2c_irq_stat = i2c_irq_en_q &
                        {~to_apb_stat_i.full, ~to_i2c_stat_i.empty, mbox_i.to_i2c_new};
  assign apb_irq_stat = apb_irq_en_q &
                        {~to_i2c_stat_i.full, ~to_apb_stat_i.empty, mbox_i.to_apb_new};

  // common map decode, own_rd_ofs selects which fifo head this side may see
  function automatic i2c_periph_pkg::data_t map_read(
    input i2c_periph_pkg::reg_idx_t idx,
    input i2c_periph_pkg::reg_idx_t own_rd_ofs,
    input i2c_periph_pkg::data_t    own_head
  );
    i2c_periph_pkg::data_t val;
    val = '0;
    if (idx == own_rd_ofs) begin
      val = own_head;
    end else begin
      case (i2c_periph_pkg::reg_ofs_e'(idx))
        i2c_periph_pkg::OFS_DEV_ADDR:           val = {1'b0, cfg_q.dev_addr};
        i2c_periph_pkg::OFS_ENABLE:             val = {7'b0, cfg_q.enable};
        i2c_periph_pkg::OFS_DEBOUNCE:           val = cfg_q.debounce;
        i2c_periph_pkg::OFS_SCL_DELAY:          val = cfg_q.scl_delay;
        i2c_periph_pkg::OFS_SDA_DELAY:          val = cfg_q.sda_delay;
        i2c_periph_pkg::OFS_MBOX_TO_APB:        val = mbox_i.to_apb_data;
        i2c_periph_pkg::OFS_MBOX_TO_APB_STATUS: val = {7'b0, mbox_i.to_apb_new};
        i2c_periph_pkg::OFS_MBOX_TO_I2C:        val = mbox_i.to_i2c_data;
        i2c_periph_pkg::OFS_MBOX_TO_I2C_STATUS: val = {7'b0, mbox_i.to_i2c_new};
        i2c_periph_pkg::OFS_FIFO_TO_APB_STATUS: val = {1'b0, to_apb_stat_i};
        i2c_periph_pkg::OFS_FIFO_TO_I2C_STATUS: val = {1'b0, to_i2c_stat_i};
        i2c_periph_pkg::OFS_I2C_IRQ_STATUS:     val = {5'b0, i2c_irq_stat};
        i2c_periph_pkg::OFS_I2C_IRQ_ENABLE:     val = {5'b0, i2c_irq_en_q};
        i2c_periph_pkg::OFS_APB_IRQ_STATUS:     val = {5'b0, apb_irq_stat};
        i2c_periph_pkg::OFS_APB_IRQ_ENABLE:     val = {5'b0, apb_irq_en_q};
        default:                                val = '0;  // wdata ports, flush, holes
      endcase
    end
    return val;
  endfunction

  always_comb begin
    apb_rd_mux = '0;
    if (i2c_periph_pkg::apb_in_map(apb_i.raddr)) begin
      apb_rd_mux = map_read(apb_ridx, i2c_periph_pkg::OFS_FIFO_TO_APB_RDATA, to_apb_head_i);
    end
    i2c_rd_mux = map_read(i2c_i.addr, i2c_periph_pkg::OFS_FIFO_TO_I2C_RDATA, to_i2c_head_i);
  end

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      apb_rdata_q <= '0;
      i2c_rdata_q <= '0;
    end else begin
      apb_rdata_q <= {24'b0, apb_rd_mux};  // one cycle after raddr
      i2c_rdata_q <= i2c_rd_mux;
    end
  end

  assign apb_rdata_o = apb_rdata_q;
  assign i2c_rdata_o = i2c_rdata_q;
  assign cfg_o       = cfg_q;
  assign i2c_irq_o   = |i2c_irq_stat;
  assign apb_irq_o   = |apb_irq_stat;

endmodule

/* i2c_periph_mailbox.sv */
// one-byte mailboxes in both directions with their new-message flags
module i2c_periph_mailbox (
  input  logic                       rst_i,  // clock
  input  logic                       clk_i,  // async reset, active high
  input  i2c_periph_pkg::apb_bus_t   apb_i,
  input  i2c_periph_pkg::i2c_bus_t   i2c_i,
  output i2c_periph_pkg::mbox_stat_t stat_o
);

  logic to_apb_wr, to_apb_rd;
  logic to_i2c_wr, to_i2c_rd;
  logic to_apb_new_q, to_i2c_new_q;
  i2c_periph_pkg::data_t to_apb_data_q, to_i2c_data_q;

  // i2c posts to apb at 0x10, apb consumes it at 4x that
  assign to_apb_wr = i2c_i.we && (i2c_i.addr == i2c_periph_pkg::OFS_MBOX_TO_APB);
  assign to_apb_rd = apb_i.rd_done && i2c_periph_pkg::apb_in_map(apb_i.raddr) &&
                     (i2c_periph_pkg::apb_index(apb_i.raddr) == i2c_periph_pkg::OFS_MBOX_TO_APB);

  // and the other way round at 0x12
  assign to_i2c_wr = apb_i.we && i2c_periph_pkg::apb_in_map(apb_i.waddr) &&
                     (i2c_periph_pkg::apb_index(apb_i.waddr) == i2c_periph_pkg::OFS_MBOX_TO_I2C);
  assign to_i2c_rd = i2c_i.rd_done && (i2c_i.addr == i2c_periph_pkg::OFS_MBOX_TO_I2C);

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      to_apb_new_q <= 1'b0;
      to_i2c_new_q <= 1'b0;
    end else begin
      if (to_apb_wr) to_apb_new_q <= 1'b1;  // a new write beats a same-cycle read
      else if (to_apb_rd) to_apb_new_q <= 1'b0;
      if (to_i2c_wr) to_i2c_new_q <= 1'b1;
      else if (to_i2c_rd) to_i2c_new_q <= 1'b0;
    end
  end

  // message bytes
  always_ff @(posedge rst_i) begin
    if (to_apb_wr) to_apb_data_q <= i2c_i.wdata;
    if (to_i2c_wr) to_i2c_data_q <= apb_i.wdata[7:0];
  end

  assign stat_o = '{
    to_apb_data: to_apb_data_q,
    to_apb_new:  to_apb_new_q,
    to_i2c_data: to_i2c_data_q,
    to_i2c_new:  to_i2c_new_q
  };

endmodule

/* i2c_periph_pkg.sv */
// shared types, reset defaults, register map offsets and bus structs for the i2c peripheral bridge
package i2c_periph_pkg;

  typedef logic [7:0]  data_t;      // mailbox, fifo and i2c byte
  typedef logic [11:0] apb_addr_t;  // apb byte address
  typedef logic [7:0]  reg_idx_t;   // register index as seen from i2c

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;    // pointer width for FIFO_DEPTH entries

  typedef logic [FIFO_AW-1:0] ptr_t;
  typedef logic [FIFO_AW:0]   level_t;  // 0 .. FIFO_DEPTH

  localparam logic [6:0] DEF_DEV_ADDR  = 7'h6F;
  localparam data_t      DEF_DEBOUNCE  = 8'd20;
  localparam data_t      DEF_SCL_DELAY = 8'd20;
  localparam data_t      DEF_SDA_DELAY = 8'd8;

  // register map, i2c offsets; apb reaches each one at 4x
  typedef enum logic [7:0] {
    OFS_DEV_ADDR           = 8'h00,
    OFS_ENABLE             = 8'h01,
    OFS_DEBOUNCE           = 8'h02,
    OFS_SCL_DELAY          = 8'h03,
    OFS_SDA_DELAY          = 8'h04,
    OFS_MBOX_TO_APB        = 8'h10,
    OFS_MBOX_TO_APB_STATUS = 8'h11,
    OFS_MBOX_TO_I2C        = 8'h12,
    OFS_MBOX_TO_I2C_STATUS = 8'h13,
    OFS_FIFO_TO_APB_WDATA  = 8'h20,
    OFS_FIFO_TO_APB_RDATA  = 8'h21,
    OFS_FIFO_TO_APB_FLUSH  = 8'h22,
    OFS_FIFO_TO_APB_STATUS = 8'h23,
    OFS_FIFO_TO_I2C_WDATA  = 8'h30,
    OFS_FIFO_TO_I2C_RDATA  = 8'h31,
    OFS_FIFO_TO_I2C_FLUSH  = 8'h32,
    OFS_FIFO_TO_I2C_STATUS = 8'h33,
    OFS_I2C_IRQ_STATUS     = 8'h40,
    OFS_I2C_IRQ_ENABLE     = 8'h41,
    OFS_APB_IRQ_STATUS     = 8'h50,
    OFS_APB_IRQ_ENABLE     = 8'h51
  } reg_ofs_e;

  typedef struct packed {
    apb_addr_t   waddr;
    logic [31:0] wdata;
    logic        we;
    apb_addr_t   raddr;
    logic        rd_done;  // reader consumed the byte at raddr
  } apb_bus_t;

  typedef struct packed {
    reg_idx_t addr;     // shared by reads and writes
    data_t    wdata;
    logic     we;
    logic     rd_done;
  } i2c_bus_t;

  typedef struct packed {
    logic [6:0] dev_addr;
    logic       enable;
    data_t      debounce;
    data_t      scl_delay;
    data_t      sda_delay;
  } i2c_cfg_t;

  // read back as {level, full, empty}
  typedef struct packed {
    level_t level;
    logic   full;
    logic   empty;
  } fifo_stat_t;

  typedef struct packed {
    data_t to_apb_data;
    logic  to_apb_new;
    data_t to_i2c_data;
    logic  to_i2c_new;
  } mbox_stat_t;

  // apb only hits the map when the upper address bits are clear
  function automatic logic apb_in_map(input apb_addr_t addr);
    return addr[11:10] == 2'b00;
  endfunction

  function automatic reg_idx_t apb_index(input apb_addr_t addr);
    return addr[9:2];  // word aligned
  endfunction

endpackage

/* i2c_periph_top.f */
i2c_periph_pkg.sv
i2c_byte_fifo.sv
i2c_periph_mailbox.sv
i2c_periph_csr.sv
i2c_periph_top.sv
i2c_periph_assertions.sv
tb_clock_gen.sv
tb_i2c_periph.sv

/* i2c_periph_top.sv */
// top of the apb to i2c register bridge, wires config block, mailboxes and both fifos
module i2c_periph_top (
  input  logic                     rst_i,  // clock
  input  logic                     clk_i,  // async reset, active high
  input  i2c_periph_pkg::apb_bus_t apb_i,
  input  i2c_periph_pkg::i2c_bus_t i2c_i,
  output logic [31:0]              apb_rdata_o,
  output i2c_periph_pkg::data_t    i2c_rdata_o,
  output i2c_periph_pkg::i2c_cfg_t cfg_o,
  output logic                     i2c_irq_o,
  output logic                     apb_irq_o
);

  i2c_periph_pkg::mbox_stat_t mbox_stat;
  i2c_periph_pkg::fifo_stat_t to_apb_stat, to_i2c_stat;
  i2c_periph_pkg::data_t to_apb_head, to_i2c_head;

  i2c_periph_mailbox u_mailbox (
    .rst_i (rst_i),
    .clk_i (clk_i),
    .apb_i (apb_i),
    .i2c_i (i2c_i),
    .stat_o(mbox_stat)
  );

  // i2c writes, apb reads
  i2c_byte_fifo u_fifo_to_apb (
    .rst_i       (rst_i),
    .clk_i       (clk_i),
    .wr_bus_apb_i(1'b0),
    .apb_i       (apb_i),
    .i2c_i       (i2c_i),
    .stat_o      (to_apb_stat),
    .head_o      (to_apb_head)
  );

  // apb writes, i2c reads
  i2c_byte_fifo u_fifo_to_i2c (
    .rst_i       (rst_i),
    .clk_i       (clk_i),
    .wr_bus_apb_i(1'b1),
    .apb_i       (apb_i),
    .i2c_i       (i2c_i),
    .stat_o      (to_i2c_stat),
    .head_o      (to_i2c_head)
  );

  i2c_periph_csr u_csr (
    .rst_i        (rst_i),
    .clk_i        (clk_i),
    .apb_i        (apb_i),
    .i2c_i        (i2c_i),
    .mbox_i       (mbox_stat),
    .to_apb_stat_i(to_apb_stat),
    .to_i2c_stat_i(to_i2c_stat),
    .to_apb_head_i(to_apb_head),
    .to_i2c_head_i(to_i2c_head),
    .apb_rdata_o  (apb_rdata_o),
    .i2c_rdata_o  (i2c_rdata_o),
    .cfg_o        (cfg_o),
    .i2c_irq_o    (i2c_irq_o),
    .apb_irq_o    (apb_irq_o)
  );

endmodule

/* tb_clock_gen.sv */
// free-running testbench clock with a period of 100 time units
module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // 50 high, 50 low
  end

endmodule

/* tb_i2c_periph.sv */
// table-driven testbench for the apb to i2c register bridge, run through the Makefile sim target
module tb_i2c_periph;

  typedef enum logic {SIDE_APB, SIDE_I2C} side_e;
  typedef enum logic [1:0] {OP_WR, OP_RD, OP_DONE, OP_IRQ} op_e;

  typedef struct packed {
    side_e       side;
    op_e         op;
    logic [11:0] addr;  // apb byte address or i2c index
    logic [7:0]  data;
    logic [7:0]  exp;   // read value, or interrupt level in bit 0
  } row_t;

  logic rst;  // clock
  logic clk;  // reset
  i2c_periph_pkg::apb_bus_t apb;
  i2c_periph_pkg::i2c_bus_t i2c;
  logic [31:0] apb_rdata_o;
  logic [7:0] i2c_rdata_o;
  i2c_periph_pkg::i2c_cfg_t cfg_o;
  logic i2c_irq_o, apb_irq_o;

  row_t rows[$];
  i2c_periph_pkg::i2c_cfg_t cfg_exp;  // expected configuration, follows apb writes
  logic [31:0] lcg_state;

  tb_clock_gen u_clock_gen (.clk_o(rst));

  i2c_periph_top u_i2c_periph_top (
    .rst_i      (rst),
    .clk_i      (clk),
    .apb_i      (apb),
    .i2c_i      (i2c),
    .apb_rdata_o(apb_rdata_o),
    .i2c_rdata_o(i2c_rdata_o),
    .cfg_o      (cfg_o),
    .i2c_irq_o  (i2c_irq_o),
    .apb_irq_o  (apb_irq_o)
  );

  bind i2c_periph_top i2c_periph_assertions u_assertions (
    .rst_i        (rst_i),
    .clk_i        (clk_i),
    .i2c_irq_en_i (u_csr.i2c_irq_en_q),
    .apb_irq_en_i (u_csr.apb_irq_en_q),
    .i2c_irq_i    (i2c_irq_o),
    .apb_irq_i    (apb_irq_o),
    .to_apb_stat_i(to_apb_stat),
    .to_i2c_stat_i(to_i2c_stat)
  );

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // status word: bit 0 empty, bit 1 full, bits 6:2 level
  function automatic logic [7:0] stat_byte(input int n);
    logic [4:0] lvl;
    lvl = n[4:0];
    return {1'b0, lvl, n == 16, n == 0};
  endfunction

  task automatic add_apb(input op_e op, input logic [7:0] idx, input logic [7:0] data,
                         input logic [7:0] exp);
    rows.push_back('{side: SIDE_APB, op: op, addr: {2'b00, idx, 2'b00}, data: data, exp: exp});
  endtask

  task automatic add_i2c(input op_e op, input logic [7:0] idx, input logic [7:0] data,
                         input logic [7:0] exp);
    rows.push_back('{side: SIDE_I2C, op: op, addr: {4'h0, idx}, data: data, exp: exp});
  endtask

  task automatic build_table();
    logic [7:0] to_apb_q[$];
    logic [7:0] to_i2c_q[$];
    logic [7:0] b;
    // reset defaults on both sides
    add_apb(OP_RD, 8'h00, 8'h00, 8'h6F);
    add_apb(OP_RD, 8'h02, 8'h00, 8'd20);
    add_i2c(OP_RD, 8'h01, 8'h00, 8'h00);
    add_i2c(OP_RD, 8'h03, 8'h00, 8'd20);
    add_i2c(OP_RD, 8'h04, 8'h00, 8'd8);
    add_apb(OP_RD, 8'h23, 8'h00, stat_byte(0));
    add_i2c(OP_RD, 8'h33, 8'h00, stat_byte(0));
    add_apb(OP_IRQ, 8'h00, 8'h00, 8'h00);
    add_i2c(OP_IRQ, 8'h00, 8'h00, 8'h00);
    // configuration writes, dev_addr keeps 7 bits
    add_apb(OP_WR, 8'h00, 8'hB5, 8'h00);
    add_apb(OP_WR, 8'h01, 8'h01, 8'h00);
    add_apb(OP_WR, 8'h02, 8'h33, 8'h00);
    add_apb(OP_WR, 8'h03, 8'h44, 8'h00);
    add_apb(OP_WR, 8'h04, 8'h11, 8'h00);
    rows.push_back('{side: SIDE_APB, op: OP_WR, addr: 12'h408, data: 8'h99, exp: 8'h00});
    add_i2c(OP_RD, 8'h00, 8'h00, 8'h35);
    add_i2c(OP_RD, 8'h01, 8'h00, 8'h01);
    add_i2c(OP_RD, 8'h02, 8'h00, 8'h33);
    add_i2c(OP_RD, 8'h04, 8'h00, 8'h11);
    // mailbox toward apb
    add_i2c(OP_WR, 8'h10, 8'hA5, 8'h00);
    add_apb(OP_RD, 8'h11, 8'h00, 8'h01);
    add_apb(OP_RD, 8'h10, 8'h00, 8'hA5);
    add_apb(OP_IRQ, 8'h00, 8'h00, 8'h00);
    add_apb(OP_WR, 8'h51, 8'h01, 8'h00);
    add_apb(OP_IRQ, 8'h00, 8'h00, 8'h01);
    add_apb(OP_DONE, 8'h10, 8'h00, 8'h00);
    add_apb(OP_RD, 8'h11, 8'h00, 8'h00);
    add_apb(OP_IRQ, 8'h00, 8'h00, 8'h00);
    // mailbox toward i2c
    add_apb(OP_WR, 8'h12, 8'h5A, 8'h00);
    add_i2c(OP_RD, 8'h13, 8'h00, 8'h01);
    add_i2c(OP_RD, 8'h12, 8'h00, 8'h5A);
    add_i2c(OP_WR, 8'h41, 8'h01, 8'h00);
    add_i2c(OP_IRQ, 8'h00, 8'h00, 8'h01);
    add_i2c(OP_DONE, 8'h12, 8'h00, 8'h00);
    add_i2c(OP_RD, 8'h13, 8'h00, 8'h00);
    add_i2c(OP_IRQ, 8'h00, 8'h00, 8'h00);
    add_i2c(OP_WR, 8'h41, 8'h00, 8'h00);
    add_apb(OP_WR, 8'h51, 8'h00, 8'h00);
    // fifo toward apb, the last two pushes are dropped
    for (int i = 0; i < 18; i++) begin
      b = rand_byte();
      add_i2c(OP_WR, 8'h20, b, 8'h00);
      if (to_apb_q.size() < 16) to_apb_q.push_back(b);
    end
    add_apb(OP_RD, 8'h23, 8'h00, stat_byte(to_apb_q.size()));
    add_i2c(OP_RD, 8'h23, 8'h00, stat_byte(to_apb_q.size()));
    add_i2c(OP_RD, 8'h21, 8'h00, 8'h00);  // apb read port, not visible to i2c
    add_apb(OP_RD, 8'h20, 8'h00, 8'h00);
    for (int i = 0; i < 4; i++) begin
      add_apb(OP_RD, 8'h21, 8'h00, to_apb_q[0]);
      add_apb(OP_DONE, 8'h21, 8'h00, 8'h00);
      void'(to_apb_q.pop_front());
      add_apb(OP_RD, 8'h23, 8'h00, stat_byte(to_apb_q.size()));
    end
    add_i2c(OP_WR, 8'h22, 8'h01, 8'h00);
    to_apb_q.delete();
    add_apb(OP_RD, 8'h23, 8'h00, stat_byte(0));
    add_apb(OP_RD, 8'h21, 8'h00, 8'h00);
    add_apb(OP_WR, 8'h22, 8'h00, 8'h00);
    // fifo toward i2c with data and room interrupts
    add_i2c(OP_WR, 8'h41, 8'h02, 8'h00);
    add_i2c(OP_IRQ, 8'h00, 8'h00, 8'h00);
    add_apb(OP_WR, 8'h51, 8'h04, 8'h00);
    add_apb(OP_IRQ, 8'h00, 8'h00, 8'h01);
    for (int i = 0; i < 16; i++) begin
      b = rand_byte();
      add_apb(OP_WR, 8'h30, b, 8'h00);
      to_i2c_q.push_back(b);
    end
    add_i2c(OP_IRQ, 8'h00, 8'h00, 8'h01);
    add_apb(OP_IRQ, 8'h00, 8'h00, 8'h00);  // full, no room
    add_i2c(OP_RD, 8'h33, 8'h00, stat_byte(to_i2c_q.size()));
    while (to_i2c_q.size() > 0) begin
      add_i2c(OP_RD, 8'h31, 8'h00, to_i2c_q[0]);
      add_i2c(OP_DONE, 8'h31, 8'h00, 8'h00);
      void'(to_i2c_q.pop_front());
      add_apb(OP_IRQ, 8'h00, 8'h00, 8'h01);
    end
    add_i2c(OP_IRQ, 8'h00, 8'h00, 8'h00);
    add_i2c(OP_RD, 8'h33, 8'h00, stat_byte(0));
    add_i2c(OP_WR, 8'h41, 8'h00, 8'h00);
    add_apb(OP_WR, 8'h51, 8'h00, 8'h00);
    add_apb(OP_IRQ, 8'h00, 8'h00, 8'h00);
    add_i2c(OP_IRQ, 8'h00, 8'h00, 8'h00);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: time %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic step();
    @(posedge rst);
    #10;
  endtask

  task automatic wait_irq(input side_e side, input logic level);
    int n;
    logic irq;
    n = 0;
    irq = (side == SIDE_APB) ? apb_irq_o : i2c_irq_o;
    while (irq !== level && n < 20) begin
      step();
      n++;
      irq = (side == SIDE_APB) ? apb_irq_o : i2c_irq_o;
    end
    if (irq !== level) begin
      $display("error: time %0t %s interrupt did not reach %0d within 20 cycles",
               $time, side.name(), level);
      $display("STATUS: FAIL");
      $fatal(1, "interrupt wait timed out");
    end
  endtask

  task automatic apply_row(input row_t r);
    case (r.op)
      OP_WR: begin
        if (r.side == SIDE_APB) begin
          apb.waddr = r.addr;
          apb.wdata = {24'b0, r.data};
          apb.we    = 1'b1;
          if (r.addr[11:10] == 2'b00) begin
            case (r.addr[9:2])
              8'h00:   cfg_exp.dev_addr  = r.data[6:0];
              8'h01:   cfg_exp.enable    = r.data[0];
              8'h02:   cfg_exp.debounce  = r.data;
              8'h03:   cfg_exp.scl_delay = r.data;
              8'h04:   cfg_exp.sda_delay = r.data;
              default: ;
            endcase
          end
        end else begin
          i2c.addr  = r.addr[7:0];
          i2c.wdata = r.data;
          i2c.we    = 1'b1;
        end
        step();
        apb.we = 1'b0;
        i2c.we = 1'b0;
        step();  // push, then status
        step();
      end
      OP_RD: begin
        if (r.side == SIDE_APB) begin
          apb.raddr = r.addr;
          step();
          compare_value("apb_rdata_o", apb_rdata_o, {24'b0, r.exp});
        end else begin
          i2c.addr = r.addr[7:0];
          step();
          compare_value("i2c_rdata_o", i2c_rdata_o, r.exp);
        end
      end
      OP_DONE: begin
        if (r.side == SIDE_APB) begin
          apb.raddr   = r.addr;
          apb.rd_done = 1'b1;
        end else begin
          i2c.addr    = r.addr[7:0];
          i2c.rd_done = 1'b1;
        end
        step();
        apb.rd_done = 1'b0;
        i2c.rd_done = 1'b0;
        step();  // pop, then status
        step();
      end
      default: wait_irq(r.side, r.exp[0]);
    endcase
    compare_value("cfg_o", cfg_o, cfg_exp);
  endtask

  initial begin
    clk       = 1'b1;
    apb       = '0;
    i2c       = '0;
    lcg_state = 32'd77982;
    cfg_exp   = '{dev_addr: 7'h6F, enable: 1'b0, debounce: 8'd20,
                  scl_delay: 8'd20, sda_delay: 8'd8};
    build_table();
    repeat (10) @(posedge rst);
    #10;
    clk = 1'b0;
    compare_value("i2c_irq_o", i2c_irq_o, 0);
    compare_value("apb_irq_o", apb_irq_o, 0);
    compare_value("apb_rdata_o", apb_rdata_o, 0);
    compare_value("i2c_rdata_o", i2c_rdata_o, 0);
    foreach (rows[k]) begin
      apply_row(rows[k]);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule
